// ==== Makefile ====
VERILATOR ?= verilator
LOG ?= sim.log
SEED_ARGS ?=
OBJ_DIR ?= obj_dir

TOP := tb_fp_cmp_unit
FLIST := fp_cmp_unit.f
SRCS := $(wildcard hw/*.sv) $(wildcard test/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --assert --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) $(SEED_ARGS) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if [ $$st -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fp_cmp_unit.f ====
hw/fp96_pkg.sv
hw/fp_decomp96.sv
hw/fp_compare96.sv
hw/fp_queue.sv
hw/fp_cmp_pipe.sv
hw/fp_cmp_unit.sv
test/tb_fp_cmp_unit.sv

// ==== hw/fp96_pkg.sv ====
// shared FP96 format constants, payload structs and queue depths, reached by scoped names
`default_nettype none

package fp96_pkg;

	// ======================================================================
	// format constants
	// ======================================================================

	// top exponent bit, exponent is 15 bits wide
	localparam int EMSB = 14;
	// top fraction bit, doubles as the quiet bit of a nan
	localparam int FMSB = 79;

	// ======================================================================
	// buffering
	// ======================================================================

	// both depths must stay powers of two
	localparam int OPQ_DEPTH = 8;
	localparam int RESQ_DEPTH = 8;

	// ======================================================================
	// payload types
	// ======================================================================

	// 96 bit value: sign, biased exponent, fraction
	// no hidden bit is stored
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FMSB:0] man;
	} FP96;

	// one compare request, 192 bits, a is the left operand
	typedef struct packed {
		FP96 a;
		FP96 b;
	} fp_pair_t;

	// compare result, 18 bits
	// cond bits: 0 eq, 1 lt, 2 le, 3 magnitude lt, 4 unordered
	// bits 8 to 12 hold the complements of bits 0 to 4, the rest read zero
	typedef struct packed {
		logic [15:0] cond;
		logic nan;
		logic snan;
	} cmp_result_t;

endpackage

`default_nettype wire

// ==== hw/fp_cmp_pipe.sv ====
// two-stage compare pipeline draining the operand queue into the result queue under credit
`default_nettype none

module fp_cmp_pipe
(
	input logic clk,
	input logic rst_n,
	input logic op_valid,
	input fp96_pkg::fp_pair_t op_head,
	output logic op_pop,
	input logic [$clog2(fp96_pkg::RESQ_DEPTH):0] res_count,
	output logic res_push,
	output fp96_pkg::cmp_result_t res_in
);

	// stage 1, popped operand pair
	logic s1_valid;
	fp96_pkg::fp_pair_t s1_pair;

	// stage 2, registered result
	logic s2_valid;
	fp96_pkg::cmp_result_t s2_res;

	// comparator outputs from stage 1
	logic [15:0] cmp_cond;
	logic cmp_nan;
	logic cmp_snan;

	// credit bookkeeping
	logic [1:0] in_flight;
	logic [$clog2(fp96_pkg::RESQ_DEPTH)+1:0] occupancy;

	// ======================================================================
	// credit
	// ======================================================================

	// items already headed for the result queue
	assign in_flight = {1'b0, s1_valid} + {1'b0, s2_valid};

	// result queue contents plus everything that will still land there
	assign occupancy = {1'b0, res_count}
		+ {{($clog2(fp96_pkg::RESQ_DEPTH)){1'b0}}, in_flight};

	// pop only when the new item is guaranteed a slot
	// so the result queue never sees a push while full
	assign op_pop = op_valid
		& (occupancy < ($clog2(fp96_pkg::RESQ_DEPTH) + 2)'(fp96_pkg::RESQ_DEPTH));

	// ======================================================================
	// stages
	// ======================================================================

	fp_compare96 u_cmp
	(
		.a(s1_pair.a),
		.b(s1_pair.b),
		.o(cmp_cond),
		.nan(cmp_nan),
		.snan(cmp_snan)
	);

	// valid bits
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= op_pop;
			s2_valid <= s1_valid;
		end
	end

	// payload registers, loaded only on a valid transfer
	always_ff @(posedge clk)
	begin
		if (op_pop)
			s1_pair <= op_head;
		if (s1_valid)
			s2_res <= '{cond: cmp_cond, nan: cmp_nan, snan: cmp_snan};
	end

	// stage 2 feeds the result queue directly
	assign res_push = s2_valid;
	assign res_in = s2_res;

	// queue count from the result side plus our stages never overruns the depth
	assert property (@(posedge clk) disable iff (!rst_n)
		occupancy <= ($clog2(fp96_pkg::RESQ_DEPTH) + 2)'(fp96_pkg::RESQ_DEPTH))
	else $error("fp_cmp_pipe: credit overrun, occupancy %0d", occupancy);

endmodule

`default_nettype wire

// ==== hw/fp_cmp_unit.sv ====
// top of the buffered FP96 compare unit: host write port, operand queue, pipeline, result queue
`default_nettype none

module fp_cmp_unit
(
	input logic clk,
	input logic rst_n,
	// host write side
	input logic cmp_wr,
	input fp96_pkg::fp_pair_t cmp_pair,
	output logic cmp_full,
	// host read side
	input logic res_rd,
	output logic res_valid,
	output fp96_pkg::cmp_result_t res_data
);

	// operand queue to pipeline
	logic op_valid;
	fp96_pkg::fp_pair_t op_head;
	logic op_pop;

	// pipeline to result queue
	logic res_push;
	fp96_pkg::cmp_result_t res_in;
	logic [$clog2(fp96_pkg::RESQ_DEPTH):0] res_count;

	// ======================================================================
	// operand queue, written straight from the host strobe
	// ======================================================================

	fp_queue #(.payload_t(fp96_pkg::fp_pair_t), .DEPTH(fp96_pkg::OPQ_DEPTH)) u_opq
	(
		.clk(clk),
		.rst_n(rst_n),
		.push(cmp_wr),
		.din(cmp_pair),
		.pop(op_pop),
		.dout(op_head),
		.not_empty(op_valid),
		.full(cmp_full),
		.count()
	);

	// ======================================================================
	// compare pipeline
	// ======================================================================

	fp_cmp_pipe u_pipe
	(
		.clk(clk),
		.rst_n(rst_n),
		.op_valid(op_valid),
		.op_head(op_head),
		.op_pop(op_pop),
		.res_count(res_count),
		.res_push(res_push),
		.res_in(res_in)
	);

	// result queue, full is never reached thanks to the pipeline credit
	fp_queue #(.payload_t(fp96_pkg::cmp_result_t), .DEPTH(fp96_pkg::RESQ_DEPTH)) u_resq
	(
		.clk(clk),
		.rst_n(rst_n),
		.push(res_push),
		.din(res_in),
		.pop(res_rd),
		.dout(res_data),
		.not_empty(res_valid),
		.full(),
		.count(res_count)
	);

endmodule

`default_nettype wire

// ==== hw/fp_compare96.sv ====
// combinational FP96 compare forming the 16-bit condition word and nan/snan flags
`default_nettype none

module fp_compare96
(
	input fp96_pkg::FP96 a,
	input fp96_pkg::FP96 b,
	output logic [15:0] o,
	output logic nan,
	output logic snan
);

	// decomposed operand a
	logic sa;
	logic [fp96_pkg::EMSB:0] xa;
	logic [fp96_pkg::FMSB:0] ma;
	logic az;
	logic nan_a;
	logic snan_a;

	// decomposed operand b
	logic sb;
	logic [fp96_pkg::EMSB:0] xb;
	logic [fp96_pkg::FMSB:0] mb;
	logic bz;
	logic nan_b;
	logic snan_b;

	// intermediate relations
	logic unordered;
	logic eq;
	logic mag_lt;
	logic mag_gt;
	logic lt;

	fp_decomp96 u_dec_a (.i(a), .sgn(sa), .exp(xa), .man(ma), .vz(az), .nan(nan_a),
		.qnan(), .snan(snan_a));
	fp_decomp96 u_dec_b (.i(b), .sgn(sb), .exp(xb), .man(mb), .vz(bz), .nan(nan_b),
		.qnan(), .snan(snan_b));

	// ======================================================================
	// relations
	// ======================================================================

	// any nan makes the pair unordered
	assign unordered = nan_a | nan_b;

	// +0 and -0 are equal, otherwise bit pattern equality
	assign eq = ~unordered & ((az & bz) | (a == b));

	// magnitude order, exponent then fraction
	assign mag_lt = {xa, ma} < {xb, mb};
	assign mag_gt = {xa, ma} > {xb, mb};

	// signs differ: negative side is less unless both are zero
	// both negative: larger magnitude is less
	assign lt = ~unordered & ((sa ^ sb) ? (sa & ~(az & bz)) : (sa ? mag_gt : mag_lt));

	// ======================================================================
	// condition word
	// ======================================================================

	always_comb
	begin
		o = '0;
		o[0] = eq;
		o[1] = lt;
		o[2] = lt | eq;
		// magnitude only, sign ignored
		o[3] = mag_lt;
		o[4] = unordered;
		o[12:8] = ~o[4:0];
	end

	assign nan = unordered;
	// signalling on either side
	assign snan = snan_a | snan_b;

	// eq needs equal bits or two zeros, lt needs an ordered difference
	always_comb
	begin
		assert final (!(eq && lt))
		else $error("fp_compare96: eq and lt both set");
	end

endmodule

`default_nettype wire

// ==== hw/fp_decomp96.sv ====
// field split and nan/zero classification of one FP96 value, used by the comparator
`default_nettype none

module fp_decomp96
(
	input fp96_pkg::FP96 i,
	output logic sgn,
	output logic [fp96_pkg::EMSB:0] exp,
	output logic [fp96_pkg::FMSB:0] man,
	output logic vz,
	output logic nan,
	output logic qnan,
	output logic snan
);

	// exponent all ones, used for both inf and nan
	logic exp_max;
	// any fraction bit set
	logic man_nz;

	// raw fields, no bias removal
	assign sgn = i.sign;
	assign exp = i.exp;
	assign man = i.man;

	assign exp_max = &i.exp;
	assign man_nz = |i.man;

	// zero of either sign
	// denormals are not zero here, they keep their bit pattern
	assign vz = ~|i.exp & ~man_nz;

	// inf has a zero fraction, so it is not a nan
	assign nan = exp_max & man_nz;

	// quiet bit set means quiet nan
	assign qnan = nan & i.man[fp96_pkg::FMSB];
	// quiet bit clear on a nan, payload is nonzero by definition
	assign snan = nan & ~i.man[fp96_pkg::FMSB];

endmodule

`default_nettype wire

// ==== hw/fp_queue.sv ====
// first-word-fall-through queue over any packed payload, instantiated for operands and results
`default_nettype none

module fp_queue
#(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 8
)
(
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t din,
	input logic pop,
	output payload_t dout,
	output logic not_empty,
	output logic full,
	output logic [$clog2(DEPTH):0] count
);

	// ======================================================================
	// storage and pointers
	// ======================================================================

	// circular buffer whose power of two depth lets the pointers wrap on their own
	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;

	// qualified strobes
	logic do_push;
	logic do_pop;

	// a push into a full queue is dropped
	assign do_push = push & ~full;
	// a pop on an empty queue is dropped
	assign do_pop = pop & not_empty;

	// payload storage written on an accepted push
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// ======================================================================
	// control
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1;
			// push and pop together leave count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1;
				2'b01: count <= count - 1;
				default: count <= count;
			endcase
		end
	end

	// head is visible the edge after it was pushed
	assign dout = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign full = (count == ($clog2(DEPTH) + 1)'(DEPTH));

	// upstream must watch full
	assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
	else $error("fp_queue: push while full");

	// downstream must watch not_empty
	assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty)
	else $error("fp_queue: pop while empty");

endmodule

`default_nettype wire

// ==== test/tb_fp_cmp_unit.sv ====
// random-stimulus testbench for the FP96 compare unit, checks every result against a local model
`default_nettype none

module tb_fp_cmp_unit;

	localparam int WAIT_LIMIT = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic cmp_wr;
	fp96_pkg::fp_pair_t cmp_pair;
	logic cmp_full;
	logic res_rd;
	logic res_valid;
	fp96_pkg::cmp_result_t res_data;

	integer seed;
	int errors;
	// scoreboard holding one entry per accepted write in write order
	fp96_pkg::cmp_result_t expected[$];

	fp_cmp_unit u_fp_cmp_unit (.clk(clk), .rst_n(rst_n), .cmp_wr(cmp_wr), .cmp_pair(cmp_pair),
		.cmp_full(cmp_full), .res_rd(res_rd), .res_valid(res_valid), .res_data(res_data));

	always #50 clk = ~clk;

	// ======================================================================
	// reference model and value generators
	// ======================================================================

	function automatic fp96_pkg::cmp_result_t model_compare(input fp96_pkg::FP96 a,
		input fp96_pkg::FP96 b);
		fp96_pkg::cmp_result_t r;
		logic a_nan, b_nan, unord, both_zero, eq, lt, le, mlt;
		logic [94:0] mag_a, mag_b;
		a_nan = (a.exp == '1) && (a.man != '0);
		b_nan = (b.exp == '1) && (b.man != '0);
		unord = a_nan || b_nan;
		mag_a = {a.exp, a.man};
		mag_b = {b.exp, b.man};
		mlt = mag_a < mag_b;
		// both zero whatever the signs
		both_zero = (mag_a == '0) && (mag_b == '0);
		eq = !unord && (both_zero || (a == b));
		if (unord || both_zero)
			lt = 1'b0;
		else if (a.sign != b.sign)
			lt = a.sign;
		else if (a.sign)
			lt = mag_b < mag_a;
		else
			lt = mlt;
		le = lt || eq;
		r.cond = {3'b000, ~unord, ~mlt, ~le, ~lt, ~eq, 3'b000, unord, mlt, le, lt, eq};
		r.nan = unord;
		// signaling means quiet bit clear
		r.snan = (a_nan && !a.man[79]) || (b_nan && !b.man[79]);
		return r;
	endfunction

	function automatic fp96_pkg::FP96 fp(input logic s, input logic [14:0] e,
		input logic [79:0] m);
		fp96_pkg::FP96 v;
		v.sign = s;
		v.exp = e;
		v.man = m;
		return v;
	endfunction

	function automatic fp96_pkg::FP96 rand_finite();
		logic [31:0] r0, r1, r2;
		fp96_pkg::FP96 v;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		v = fp(r0[31], r0[14:0], {r1, r2, r0[31:16]});
		// all-ones exponent is inf or nan
		if (v.exp == 15'h7fff)
			v.exp = 15'h7ffe;
		return v;
	endfunction

	function automatic fp96_pkg::FP96 make_nan(input logic quiet, input logic s);
		logic [31:0] r0, r1, r2;
		fp96_pkg::FP96 v;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		v = fp(s, 15'h7fff, {quiet, r1, r2, r0[14:0]});
		// snan payload must stay nonzero
		if (v.man == '0)
			v.man[0] = 1'b1;
		return v;
	endfunction

	// random pairs biased towards near and equal values with an optional nan side
	function automatic fp96_pkg::fp_pair_t rand_pair(input logic allow_nan);
		logic [31:0] r;
		fp96_pkg::fp_pair_t p;
		r = $random(seed);
		p.a = rand_finite();
		p.b = rand_finite();
		case (r[2:0])
			3'd0: p.b = p.a;
			3'd1: p.b = fp(~p.a.sign, p.a.exp, p.a.man);
			3'd2: p.b = fp(p.a.sign, p.a.exp, p.a.man ^ (80'h1 << r[9:3]));
			3'd3: p.b.exp = p.a.exp;
			default: ;
		endcase
		if (allow_nan && r[15:12] == 4'h0)
			p.a = make_nan(r[16], r[17]);
		if (allow_nan && r[15:12] == 4'h1)
			p.b = make_nan(r[16], r[17]);
		return p;
	endfunction

	// ======================================================================
	// drive, check and wait
	// ======================================================================

	task automatic finish_run();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic timeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
		finish_run();
	endtask

	task automatic check_head();
		fp96_pkg::cmp_result_t e;
		if (expected.size() == 0)
		begin
			errors++;
			$display("result read with no write left to match it");
		end
		else
		begin
			e = expected.pop_front();
			assert (res_data.cond == e.cond)
			else
			begin
				errors++;
				$display("CHECK FAILED res_data.cond expected %h actual %h",
					e.cond, res_data.cond);
			end
			assert (res_data.nan == e.nan && res_data.snan == e.snan)
			else
			begin
				errors++;
				$display("CHECK FAILED res_data.nan/snan expected %h actual %h",
					{e.nan, e.snan}, {res_data.nan, res_data.snan});
			end
		end
	endtask

	// one cycle from a falling edge to the next with the head checked before a read
	task automatic step(input logic wr, input fp96_pkg::fp_pair_t pair, input logic rd);
		if (rd)
			check_head();
		cmp_wr = wr;
		cmp_pair = pair;
		res_rd = rd;
		if (wr)
			expected.push_back(model_compare(pair.a, pair.b));
		@(negedge clk);
		cmp_wr = 1'b0;
		res_rd = 1'b0;
	endtask

	// write once there is room and read whatever is ready meanwhile
	task automatic send_pair(input fp96_pkg::fp_pair_t pair);
		int waited;
		waited = 0;
		while (cmp_full && waited < WAIT_LIMIT)
		begin
			step(1'b0, '0, res_valid);
			waited++;
		end
		if (cmp_full)
			timeout("room in the operand queue");
		else
			step(1'b1, pair, res_valid);
	endtask

	task automatic drain_all();
		int waited;
		while (expected.size() > 0)
		begin
			waited = 0;
			while (!res_valid && waited < WAIT_LIMIT)
			begin
				step(1'b0, '0, 1'b0);
				waited++;
			end
			if (!res_valid)
				timeout("a result that never arrived");
			else
				step(1'b0, '0, 1'b1);
		end
		assert (!res_valid)
		else
		begin
			errors++;
			$display("result queue still holds data after all results were read");
		end
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================

	initial
	begin
		int edges;
		int accepted;
		logic [31:0] r;
		fp96_pkg::FP96 v;
		seed = 32'h29bf5557;
		errors = 0;
		rst_n = 1'b0;
		cmp_wr = 1'b0;
		cmp_pair = '0;
		res_rd = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (!cmp_full && !res_valid)
		else
		begin
			errors++;
			$display("status levels not low after reset");
		end

		// latency from an empty unit
		step(1'b1, rand_pair(1'b0), 1'b0);
		edges = 0;
		while (!res_valid && edges < WAIT_LIMIT)
		begin
			step(1'b0, '0, 1'b0);
			edges++;
		end
		assert (edges == 3)
		else
		begin
			errors++;
			$display("CHECK FAILED res_valid latency expected %h actual %h", 3, edges);
		end
		drain_all();

		// ordinary values
		repeat (400) send_pair(rand_pair(1'b0));

		// signed zeros, equal values, negative order, magnitude bit, inf, denormal
		send_pair('{a: fp(1'b0, 15'h0, 80'h0), b: fp(1'b1, 15'h0, 80'h0)});
		send_pair('{a: fp(1'b1, 15'h0, 80'h0), b: fp(1'b0, 15'h0, 80'h0)});
		send_pair('{a: fp(1'b1, 15'h4000, 80'h1), b: fp(1'b1, 15'h3fff, 80'h1)});
		send_pair('{a: fp(1'b1, 15'h3fff, 80'h5), b: fp(1'b0, 15'h4000, 80'h0)});
		send_pair('{a: fp(1'b0, 15'h3fff, 80'h5), b: fp(1'b1, 15'h4000, 80'h0)});
		send_pair('{a: fp(1'b0, 15'h7ffe, '1), b: fp(1'b0, 15'h7fff, 80'h0)});
		send_pair('{a: fp(1'b1, 15'h7fff, 80'h0), b: fp(1'b1, 15'h7ffe, '1)});
		send_pair('{a: fp(1'b0, 15'h0, 80'h1), b: fp(1'b1, 15'h0, 80'h0)});
		repeat (20)
		begin
			v = rand_finite();
			send_pair('{a: v, b: v});
		end

		// quiet and signaling nans on either side and on both
		for (int q = 0; q < 2; q++)
		begin
			repeat (8)
			begin
				r = $random(seed);
				send_pair('{a: make_nan(q[0], r[0]), b: rand_finite()});
				send_pair('{a: rand_finite(), b: make_nan(q[0], r[1])});
				send_pair('{a: make_nan(q[0], r[2]), b: make_nan(r[3], r[4])});
			end
		end
		drain_all();

		// with no reads the pipeline stops once the result queue is full
		// and the operand queue fills behind it
		accepted = 0;
		while (!cmp_full && accepted < WAIT_LIMIT)
		begin
			step(1'b1, rand_pair(1'b1), 1'b0);
			accepted++;
		end
		assert (accepted == fp96_pkg::OPQ_DEPTH + fp96_pkg::RESQ_DEPTH)
		else
		begin
			errors++;
			$display("CHECK FAILED accepted writes expected %h actual %h",
				fp96_pkg::OPQ_DEPTH + fp96_pkg::RESQ_DEPTH, accepted);
		end
		drain_all();

		// mixed strobes with no write while full and no read while empty
		repeat (800)
		begin
			r = $random(seed);
			step(r[0] & ~cmp_full, rand_pair(1'b1), r[1] & res_valid);
		end
		drain_all();
		finish_run();
	end

endmodule

`default_nettype wire
